//--- arb_pkg.sv
`default_nettype none

package arb_pkg;

    localparam int N_MASTERS = 3;

    // one bit per master, lowest index wins.
    typedef logic [N_MASTERS-1:0] arb_vector;

    // no request and no grant share the same encoding.
    localparam arb_vector NO_GRANT = '0;

endpackage

`default_nettype wire

//--- xfer_pkg.sv
`default_nettype none

package xfer_pkg;

    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] bus_data;

    // number of the master that sent a word.
    typedef logic [1:0] src_id;

    localparam int FIFO_DEPTH = 4;

    // extra msb tells full from empty.
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_ptr;

endpackage

`default_nettype wire

//--- bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  xfer_pkg::bus_data load_data,
    input  logic              grant,
    input  logic              bus_ack,
    output logic              bus_req,
    output xfer_pkg::bus_data wdata,
    output logic              busy
);

    logic              pending;
    xfer_pkg::bus_data data_q;
    logic              done;

    assign done = grant & bus_ack; // word leaves at the next edge.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (!pending && load) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    // loads on a busy master are dropped.
    always_ff @(posedge clk) begin
        if (!pending && load) begin
            data_q <= load_data;
        end
    end

    // masked in the ack cycle so the arbiter does not grant us again.
    assign bus_req = pending & ~done;
    assign wdata   = data_q;
    assign busy    = pending;

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                bus_ack,
    input  arb_pkg::arb_vector  bus_req,
    output arb_pkg::arb_vector  bus_grant
);

    typedef enum logic {
        READY,
        BUSY
    } arb_state;

    arb_state           state;
    arb_pkg::arb_vector prio_req;

    // lowest index requester wins.
    always_comb begin : prio
        logic found;
        found    = 1'b0;
        prio_req = arb_pkg::NO_GRANT;
        for (int i = 0; i < arb_pkg::N_MASTERS; i++) begin
            if (!found && bus_req[i]) begin
                prio_req[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= arb_pkg::NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    bus_grant <= prio_req;
                    if (bus_req != arb_pkg::NO_GRANT) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (bus_ack) begin // transfer done, pick next.
                        bus_grant <= prio_req;
                        if (bus_req == arb_pkg::NO_GRANT) begin
                            state <= READY;
                        end
                    end
                end
            endcase
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(bus_grant));

    // held across target back-pressure.
    a_grant_hold: assert property (@(posedge clk) disable iff (reset)
        (bus_grant != arb_pkg::NO_GRANT && !bus_ack) |=> $stable(bus_grant));

    // a fresh grant went to a requester with no lower-index requester beside it.
    a_grant_prio: assert property (@(posedge clk) disable iff (reset)
        (!$stable(bus_grant) && bus_grant != arb_pkg::NO_GRANT) |->
            (($past(bus_req) & bus_grant) != arb_pkg::NO_GRANT) &&
            (($past(bus_req) & (bus_grant - 1'b1)) == arb_pkg::NO_GRANT));

endmodule

`default_nettype wire

//--- bus_fifo_target.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fifo_target (
    input  logic               clk,
    input  logic               reset,
    input  arb_pkg::arb_vector bus_grant,
    input  xfer_pkg::bus_data  wdata0,
    input  xfer_pkg::bus_data  wdata1,
    input  xfer_pkg::bus_data  wdata2,
    output logic               bus_ack,
    input  logic               pop,
    output logic               fifo_empty,
    output xfer_pkg::bus_data  fifo_head_data,
    output xfer_pkg::src_id    fifo_head_src
);

    xfer_pkg::bus_data data_mem [xfer_pkg::FIFO_DEPTH];
    xfer_pkg::src_id   src_mem  [xfer_pkg::FIFO_DEPTH];

    xfer_pkg::fifo_ptr wr_ptr;
    xfer_pkg::fifo_ptr rd_ptr;
    xfer_pkg::fifo_ptr fill;
    logic [$clog2(xfer_pkg::FIFO_DEPTH)-1:0] wr_addr;
    logic [$clog2(xfer_pkg::FIFO_DEPTH)-1:0] rd_addr;
    logic              fifo_full;

    xfer_pkg::bus_data sel_data;
    xfer_pkg::src_id   sel_src;

    // one-hot grant to word and master number.
    always_comb begin
        sel_data = wdata0;
        sel_src  = xfer_pkg::src_id'(0);
        if (bus_grant[1]) begin
            sel_data = wdata1;
            sel_src  = xfer_pkg::src_id'(1);
        end else if (bus_grant[2]) begin
            sel_data = wdata2;
            sel_src  = xfer_pkg::src_id'(2);
        end
    end

    assign wr_addr    = wr_ptr[$clog2(xfer_pkg::FIFO_DEPTH)-1:0];
    assign rd_addr    = rd_ptr[$clog2(xfer_pkg::FIFO_DEPTH)-1:0];
    assign fill       = wr_ptr - rd_ptr;
    assign fifo_full  = (fill == xfer_pkg::fifo_ptr'(xfer_pkg::FIFO_DEPTH));
    assign fifo_empty = (wr_ptr == rd_ptr);

    // write happens at the edge where ack is high.
    assign bus_ack = (bus_grant != arb_pkg::NO_GRANT) && !fifo_full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (bus_ack) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_ack) begin
            data_mem[wr_addr] <= sel_data;
            src_mem[wr_addr]  <= sel_src;
        end
    end

    assign fifo_head_data = data_mem[rd_addr];
    assign fifo_head_src  = src_mem[rd_addr];

    // the drain stage must respect empty.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !fifo_empty);

    a_fill_bound: assert property (@(posedge clk) disable iff (reset)
        fill <= xfer_pkg::fifo_ptr'(xfer_pkg::FIFO_DEPTH));

endmodule

`default_nettype wire

//--- stream_drain.sv
`timescale 1ns/1ps
`default_nettype none

module stream_drain (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              fifo_empty,
    input  xfer_pkg::bus_data fifo_head_data,
    input  xfer_pkg::src_id   fifo_head_src,
    output logic              pop,
    output logic              out_valid,
    output xfer_pkg::bus_data out_data,
    output xfer_pkg::src_id   out_src
);

    xfer_pkg::bus_data data_q;
    xfer_pkg::src_id   src_q;
    logic              valid_q;

    assign pop = !fifo_empty && !stall; // stall holds the head in place.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop;
        end
    end

    // payload only changes on a pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            data_q <= fifo_head_data;
            src_q  <= fifo_head_src;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;
    assign out_src   = src_q;

endmodule

`default_nettype wire

//--- arb_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module arb_bus_top (
    input  logic               clk,
    input  logic               reset,
    input  arb_pkg::arb_vector load,
    input  xfer_pkg::bus_data  load_data0,
    input  xfer_pkg::bus_data  load_data1,
    input  xfer_pkg::bus_data  load_data2,
    input  logic               stall,
    output arb_pkg::arb_vector busy,
    output logic               out_valid,
    output xfer_pkg::bus_data  out_data,
    output xfer_pkg::src_id    out_src
);

    arb_pkg::arb_vector bus_req;
    arb_pkg::arb_vector bus_grant;
    xfer_pkg::bus_data  wdata0;
    xfer_pkg::bus_data  wdata1;
    xfer_pkg::bus_data  wdata2;
    logic               bus_ack;
    logic               pop;
    logic               fifo_empty;
    xfer_pkg::bus_data  fifo_head_data;
    xfer_pkg::src_id    fifo_head_src;

    bus_master bus_master0_inst (
        .clk       (clk),
        .reset     (reset),
        .load      (load[0]),
        .load_data (load_data0),
        .grant     (bus_grant[0]),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req[0]),
        .wdata     (wdata0),
        .busy      (busy[0])
    );

    bus_master bus_master1_inst (
        .clk       (clk),
        .reset     (reset),
        .load      (load[1]),
        .load_data (load_data1),
        .grant     (bus_grant[1]),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req[1]),
        .wdata     (wdata1),
        .busy      (busy[1])
    );

    bus_master bus_master2_inst (
        .clk       (clk),
        .reset     (reset),
        .load      (load[2]),
        .load_data (load_data2),
        .grant     (bus_grant[2]),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req[2]),
        .wdata     (wdata2),
        .busy      (busy[2])
    );

    bus_arbiter bus_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .bus_grant (bus_grant)
    );

    bus_fifo_target bus_fifo_target_inst (
        .clk            (clk),
        .reset          (reset),
        .bus_grant      (bus_grant),
        .wdata0         (wdata0),
        .wdata1         (wdata1),
        .wdata2         (wdata2),
        .bus_ack        (bus_ack),
        .pop            (pop),
        .fifo_empty     (fifo_empty),
        .fifo_head_data (fifo_head_data),
        .fifo_head_src  (fifo_head_src)
    );

    stream_drain stream_drain_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .fifo_empty     (fifo_empty),
        .fifo_head_data (fifo_head_data),
        .fifo_head_src  (fifo_head_src),
        .pop            (pop),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_src        (out_src)
    );

endmodule

`default_nettype wire

//--- tb_arb_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arb_bus;

    logic               clk;
    logic               reset;
    arb_pkg::arb_vector load;
    xfer_pkg::bus_data  load_data0;
    xfer_pkg::bus_data  load_data1;
    xfer_pkg::bus_data  load_data2;
    logic               stall;
    arb_pkg::arb_vector busy;
    logic               out_valid;
    xfer_pkg::bus_data  out_data;
    xfer_pkg::src_id    out_src;

    // expected words, one queue per master.
    xfer_pkg::bus_data exp_q0[$];
    xfer_pkg::bus_data exp_q1[$];
    xfer_pkg::bus_data exp_q2[$];

    arb_pkg::arb_vector f_mask  [64];
    xfer_pkg::bus_data  f_d0    [64];
    xfer_pkg::bus_data  f_d1    [64];
    xfer_pkg::bus_data  f_d2    [64];
    int                 f_stall [64];

    int              n_lines;
    int              errors;
    int              n_out;
    int              accepted;
    int              cycles;
    int              limit;
    integer          seed;
    logic            idle;
    logic            prev_stall;
    logic            check_order;
    xfer_pkg::src_id last_src;

    arb_bus_top arb_bus_top_inst (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .load_data0 (load_data0),
        .load_data1 (load_data1),
        .load_data2 (load_data2),
        .stall      (stall),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_src    (out_src)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic push_expected(input int idx, input xfer_pkg::bus_data data);
        accepted++;
        if (idx == 0) begin
            exp_q0.push_back(data);
        end else if (idx == 1) begin
            exp_q1.push_back(data);
        end else begin
            exp_q2.push_back(data);
        end
    endtask

    task automatic check_output(input xfer_pkg::src_id src, input xfer_pkg::bus_data data);
        xfer_pkg::bus_data exp;
        logic              found;
        found = 1'b1;
        exp   = '0;
        if (src == 2'd0 && exp_q0.size() > 0) begin
            exp = exp_q0.pop_front();
        end else if (src == 2'd1 && exp_q1.size() > 0) begin
            exp = exp_q1.pop_front();
        end else if (src == 2'd2 && exp_q2.size() > 0) begin
            exp = exp_q2.pop_front();
        end else begin
            found = 1'b0;
        end
        n_out++;
        if (!found) begin
            errors++;
            $display("output word %h from master %0d was never loaded", data, src);
        end else if (data != exp) begin
            errors++;
            $display("FAIL out_data: expected %h, got %h (master %0d)", exp, data, src);
        end
        if (check_order && src < last_src) begin
            errors++;
            $display("FAIL out_src: expected at least %h, got %h", last_src, src);
        end
        last_src = src;
    endtask

    // sample at the falling edge, where loads and outputs are settled.
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid && prev_stall) begin
                errors++;
                $display("an output word appeared while stall was held");
            end
            if (out_valid) begin
                check_output(out_src, out_data);
            end
            if (load[0] && !busy[0]) begin
                push_expected(0, load_data0);
            end
            if (load[1] && !busy[1]) begin
                push_expected(1, load_data1);
            end
            if (load[2] && !busy[2]) begin
                push_expected(2, load_data2);
            end
            idle = (busy == arb_pkg::NO_GRANT) && exp_q0.size() == 0 &&
                   exp_q1.size() == 0 && exp_q2.size() == 0;
            prev_stall = stall;
        end
    end

    initial begin
        do begin
            @(posedge clk);
            cycles++;
        end while (limit == 0 || cycles <= limit);
        $display("timeout after %0d cycles, %0d errors so far", limit, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic read_vectors();
        int    fd;
        int    rc;
        int    m;
        int    a;
        int    b;
        int    c;
        int    s;
        string line;
        fd = $fopen("arb_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open arb_input.txt");
        end else begin
            while (!$feof(fd) && n_lines < 64) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    if ($sscanf(line, "%h %h %h %h %h", m, a, b, c, s) == 5) begin
                        f_mask[n_lines]  = arb_pkg::arb_vector'(m);
                        f_d0[n_lines]    = xfer_pkg::bus_data'(a);
                        f_d1[n_lines]    = xfer_pkg::bus_data'(b);
                        f_d2[n_lines]    = xfer_pkg::bus_data'(c);
                        f_stall[n_lines] = s;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (!idle);
    endtask

    task automatic run_group(input int idx);
        int n;
        int start;
        check_order = (f_stall[idx] == 0);
        last_src    = '0;
        start       = accepted;
        @(posedge clk);
        stall      <= (f_stall[idx] != 0);
        load       <= f_mask[idx];
        load_data0 <= f_d0[idx];
        load_data1 <= f_d1[idx];
        load_data2 <= f_d2[idx];
        @(posedge clk);
        load_data0 <= ~f_d0[idx]; // busy masters must drop this one.
        load_data1 <= ~f_d1[idx];
        load_data2 <= ~f_d2[idx];
        if (f_stall[idx] != 0) begin
            n = 2;
            while (n < f_stall[idx] || accepted - start < xfer_pkg::FIFO_DEPTH + 1) begin
                @(posedge clk);
                load_data0 <= f_d0[idx] + xfer_pkg::bus_data'(n);
                load_data1 <= f_d1[idx] + xfer_pkg::bus_data'(n);
                load_data2 <= f_d2[idx] + xfer_pkg::bus_data'(n);
                n++;
            end
            @(negedge clk);
            if (busy == arb_pkg::NO_GRANT) begin
                errors++;
                $display("busy dropped while the FIFO was stalled in group %0d", idx);
            end
            @(posedge clk);
            stall <= 1'b0;
        end else begin
            @(posedge clk);
        end
        load <= arb_pkg::NO_GRANT;
        wait_idle();
    endtask

    task automatic random_traffic();
        check_order = 1'b0;
        repeat (300) begin
            @(posedge clk);
            load       <= arb_pkg::arb_vector'($random(seed));
            load_data0 <= xfer_pkg::bus_data'($random(seed));
            load_data1 <= xfer_pkg::bus_data'($random(seed));
            load_data2 <= xfer_pkg::bus_data'($random(seed));
            stall      <= (($random(seed) & 3) == 0);
        end
        @(posedge clk);
        load  <= arb_pkg::NO_GRANT;
        stall <= 1'b0;
        wait_idle();
    endtask

    initial begin
        reset       = 1'b1;
        load        = arb_pkg::NO_GRANT;
        load_data0  = '0;
        load_data1  = '0;
        load_data2  = '0;
        stall       = 1'b0;
        seed        = 32'h4be5;
        n_lines     = 0;
        errors      = 0;
        n_out       = 0;
        accepted    = 0;
        cycles      = 0;
        limit       = 0;
        idle        = 1'b0;
        prev_stall  = 1'b0;
        check_order = 1'b0;
        last_src    = '0;
        read_vectors();
        limit = 200 * n_lines + 4000;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy != arb_pkg::NO_GRANT) begin
            errors++;
            $display("FAIL busy: expected %h, got %h", arb_pkg::NO_GRANT, busy);
        end
        if (out_valid) begin
            errors++;
            $display("FAIL out_valid: expected %h, got %h", 1'b0, out_valid);
        end
        repeat (5) @(posedge clk); // quiet bus, no output expected.
        for (int g = 0; g < n_lines; g++) begin
            run_group(g);
        end
        random_traffic();
        $display("run done: %0d output words, %0d errors", n_out, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- arb_input.txt
# load_mask data0 data1 data2 stall_len, all hex
# stall_len 0 runs a group without back-pressure
7 1111 2222 3333 0
1 a001 0000 0000 0
2 0000 b002 0000 0
4 0000 0000 c003 0
3 1234 5678 0000 0
5 dead 0000 beef 0
6 0000 cafe f00d 0
7 ffff 8000 0001 0
7 0f0f f0f0 aaaa 8
1 4000 0000 0000 10
6 0000 7e7e 8181 c
7 5555 6666 7777 0
5 0102 0000 0304 14
2 0000 9abc 0000 0
3 2468 1357 0000 20
7 fedc ba98 7654 0
4 0000 0000 3210 6
7 0000 0000 0000 0
7 abcd ef01 2345 18
1 ffff 0000 0000 0
6 0000 4321 8765 0

//--- compile.f
arb_pkg.sv
xfer_pkg.sv
bus_master.sv
bus_arbiter.sv
bus_fifo_target.sv
stream_drain.sv
arb_bus_top.sv
tb_arb_bus.sv

//--- Makefile
SOURCES = arb_pkg.sv xfer_pkg.sv bus_master.sv bus_arbiter.sv \
          bus_fifo_target.sv stream_drain.sv arb_bus_top.sv tb_arb_bus.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_arb_bus: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_arb_bus \
		-f compile.f -o Vtb_arb_bus

run: obj_dir/Vtb_arb_bus arb_input.txt
	./obj_dir/Vtb_arb_bus > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
